/* design/decode_sequencer.sv */
// Block-level FSM of the decoder controller
// Orders receive, syndrome check, KES, CSEE and output, and compares the
// Chien root count with the locator degree when a corrected block ends.
// A start seen during output opens the next receive alongside the output.
`timescale 1ns/1ns

module decode_sequencer (
   input  logic                 clock1,
   input  logic                 reset,
   input  logic                 start,
   input  logic                 errdetect,
   input  logic                 finish_kes,
   input  logic                 datainfinish,
   input  logic                 dataoutend,
   input  rs_ctrl_pkg::degree_t rootcntr,
   input  rs_ctrl_pkg::degree_t lambda_degree,
   output logic                 ready,
   output logic                 active_sc,
   output logic                 active_kes,
   output logic                 active_csee,
   output logic                 evalsynd,
   output logic                 errfound,
   output logic                 decode_fail,
   output logic                 en_outfifo
);
   import rs_ctrl_pkg::*;

   seq_state_t state;
   seq_state_t next_state;
   logic       roots_match;

   // Decode succeeds only if every locator root was found
   assign roots_match = (lambda_degree == rootcntr);

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         state <= seq_idle;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         seq_idle: begin
            if (start) next_state = seq_load;
         end
         seq_load: next_state = seq_receive;
         seq_receive: begin
            if (datainfinish) next_state = seq_check;
         end
         seq_check: next_state = errdetect ? seq_kes_start : seq_clean_out;
         seq_kes_start: next_state = seq_kes_wait;
         seq_kes_wait: begin
            if (finish_kes) next_state = seq_csee_start;
         end
         seq_csee_start: next_state = seq_fix_out;
         seq_fix_out: begin
            if (dataoutend) begin
               next_state = roots_match ? seq_idle : seq_fail_idle;
            end else if (start) begin
               next_state = seq_fix_out_next;
            end
         end
         seq_fix_out_next, seq_fix_out_busy: begin
            if (dataoutend) begin
               next_state = roots_match ? seq_receive : seq_fail_receive;
            end else begin
               next_state = seq_fix_out_busy;
            end
         end
         seq_fail_idle: next_state = start ? seq_load : seq_idle;
         // New block may already be complete by the time the failure is flagged
         seq_fail_receive: next_state = datainfinish ? seq_check : seq_receive;
         seq_clean_out: begin
            if (dataoutend) begin
               next_state = seq_idle;
            end else if (start) begin
               next_state = seq_clean_out_next;
            end
         end
         seq_clean_out_next, seq_clean_out_busy: begin
            next_state = dataoutend ? seq_receive : seq_clean_out_busy;
         end
         default: next_state = seq_idle;
      endcase
   end

   always_comb begin
      ready       = 1'b1;
      active_sc   = 1'b0;
      active_kes  = 1'b0;
      active_csee = 1'b0;
      evalsynd    = 1'b0;
      errfound    = 1'b0;
      decode_fail = 1'b0;
      en_outfifo  = 1'b0;
      case (state)
         seq_load: active_sc = 1'b1;
         seq_check: begin
            ready    = 1'b0;
            evalsynd = 1'b1;
         end
         seq_kes_start: begin
            ready      = 1'b0;
            active_kes = 1'b1;
            errfound   = 1'b1;
         end
         seq_kes_wait: begin
            ready      = 1'b0;
            active_kes = 1'b1;
         end
         seq_csee_start: begin
            ready       = 1'b0;
            active_kes  = 1'b1;
            active_csee = 1'b1;
         end
         seq_fix_out, seq_fix_out_busy: begin
            active_kes = 1'b1;
            en_outfifo = 1'b1;
         end
         seq_fix_out_next: begin
            active_sc  = 1'b1;
            active_kes = 1'b1;
            en_outfifo = 1'b1;
         end
         seq_fail_idle, seq_fail_receive: decode_fail = 1'b1;
         seq_clean_out, seq_clean_out_busy: en_outfifo = 1'b1;
         seq_clean_out_next: begin
            active_sc  = 1'b1;
            en_outfifo = 1'b1;
         end
         default: ready = 1'b1;
      endcase
   end

endmodule

/* design/rs_ctrl_defs.svh */
// Sizing macros for the Reed-Solomon decoder controller on 31-symbol codewords over GF(32)
// Include this header in any file that needs the codeword length or counter widths
`ifndef RS_CTRL_DEFS_SVH
`define RS_CTRL_DEFS_SVH

// Symbols per codeword
`define RS_SYMBOLS 31

// Width of a symbol counter whose all-ones value marks the last output symbol
`define RS_COUNT_W 5

// Error locator degree and Chien root count
`define RS_DEGREE_W 3

`endif

/* design/rs_ctrl_pkg.sv */
// Types shared by the decoder controller blocks
// Import it inside a module body; use scoped names in port lists
`include "rs_ctrl_defs.svh"

package rs_ctrl_pkg;

   typedef logic [`RS_COUNT_W-1:0] symbol_count_t;
   typedef logic [`RS_DEGREE_W-1:0] degree_t;

   // Block-level phases of one decode
   typedef enum logic [3:0] {
      seq_idle, seq_load, seq_receive, seq_check,
      seq_kes_start, seq_kes_wait, seq_csee_start,
      seq_fix_out, seq_fix_out_next, seq_fix_out_busy,
      seq_fail_idle, seq_fail_receive,
      seq_clean_out, seq_clean_out_next, seq_clean_out_busy
   } seq_state_t;

   // Symbol-level FIFO traffic
   typedef enum logic [3:0] {
      xfer_idle, xfer_receive, xfer_receive_last, xfer_hold,
      xfer_out_prime, xfer_out_first, xfer_out_run, xfer_out_done,
      xfer_both_first, xfer_both_run, xfer_both_done_last, xfer_both_done
   } xfer_state_t;

endpackage

/* design/rs_decode_control.sv */
// Top level of the Reed-Solomon decoder main controller
// Connects the block-level sequencer to the symbol-level transfer FSM.
// Status inputs come from the syndrome, KES and CSEE blocks.
`timescale 1ns/1ns

module rs_decode_control (
   input  logic                 clock1,
   input  logic                 reset,
   input  logic                 start,
   input  logic                 errdetect,
   input  logic                 finish_kes,
   input  rs_ctrl_pkg::degree_t rootcntr,
   input  rs_ctrl_pkg::degree_t lambda_degree,
   output logic                 ready,
   output logic                 active_sc,
   output logic                 active_kes,
   output logic                 active_csee,
   output logic                 evalsynd,
   output logic                 holdsynd,
   output logic                 errfound,
   output logic                 decode_fail,
   output logic                 dataoutstart,
   output logic                 dataoutend,
   output logic                 shift_fifo,
   output logic                 hold_fifo,
   output logic                 en_infifo,
   output logic                 en_outfifo,
   output logic                 lastdataout,
   output logic                 evalerror
);

   logic datainfinish;

   decode_sequencer sequencer_i (
      .clock1        (clock1),
      .reset         (reset),
      .start         (start),
      .errdetect     (errdetect),
      .finish_kes    (finish_kes),
      .datainfinish  (datainfinish),
      .dataoutend    (dataoutend),
      .rootcntr      (rootcntr),
      .lambda_degree (lambda_degree),
      .ready         (ready),
      .active_sc     (active_sc),
      .active_kes    (active_kes),
      .active_csee   (active_csee),
      .evalsynd      (evalsynd),
      .errfound      (errfound),
      .decode_fail   (decode_fail),
      .en_outfifo    (en_outfifo)
   );

   symbol_transfer transfer_i (
      .clock1       (clock1),
      .reset        (reset),
      .active_sc    (active_sc),
      .en_outfifo   (en_outfifo),
      .datainfinish (datainfinish),
      .dataoutstart (dataoutstart),
      .dataoutend   (dataoutend),
      .shift_fifo   (shift_fifo),
      .hold_fifo    (hold_fifo),
      .en_infifo    (en_infifo),
      .holdsynd     (holdsynd),
      .lastdataout  (lastdataout),
      .evalerror    (evalerror)
   );

endmodule

/* design/symbol_transfer.sv */
// Symbol-level FSM that drives the input and output symbol FIFOs
// Follows the sequencer one cycle later. active_sc opens a receive and
// en_outfifo opens an output. A receive opened during output is held back
// until the second output shift, so its last symbol always lands after
// dataoutend, when the sequencer is waiting for datainfinish.
`timescale 1ns/1ns
`include "rs_ctrl_defs.svh"

module symbol_transfer (
   input  logic clock1,
   input  logic reset,
   input  logic active_sc,
   input  logic en_outfifo,
   output logic datainfinish,
   output logic dataoutstart,
   output logic dataoutend,
   output logic shift_fifo,
   output logic hold_fifo,
   output logic en_infifo,
   output logic holdsynd,
   output logic lastdataout,
   output logic evalerror
);
   import rs_ctrl_pkg::*;

   xfer_state_t   state;
   xfer_state_t   next_state;
   symbol_count_t in_count;
   symbol_count_t out_count;
   logic          in_en;
   logic          out_en;

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         state     <= xfer_idle;
         in_count  <= '0;
         out_count <= '0;
      end else begin
         state     <= next_state;
         in_count  <= in_en ? in_count + symbol_count_t'(1) : '0;
         out_count <= out_en ? out_count + symbol_count_t'(1) : '0;
      end
   end

   // Counter is 0 in out_prime, so 1 on the first shift and all ones on the last
   assign dataoutstart = (out_count == symbol_count_t'(1));
   assign lastdataout  = &out_count;
   assign evalerror    = out_en;

   always_comb begin
      next_state = state;
      case (state)
         xfer_idle: begin
            if (active_sc) next_state = xfer_receive;
         end
         xfer_receive: begin
            if (in_count == symbol_count_t'(`RS_SYMBOLS - 2)) next_state = xfer_receive_last;
         end
         xfer_receive_last: next_state = xfer_hold;
         xfer_hold: begin
            if (en_outfifo) next_state = xfer_out_prime;
         end
         xfer_out_prime: next_state = active_sc ? xfer_both_first : xfer_out_first;
         xfer_out_first: next_state = active_sc ? xfer_both_first : xfer_out_run;
         xfer_out_run: begin
            if (lastdataout) begin
               next_state = active_sc ? xfer_both_done : xfer_out_done;
            end else if (active_sc) begin
               next_state = xfer_both_run;
            end
         end
         xfer_out_done: next_state = active_sc ? xfer_receive : xfer_idle;
         // Wait out the first shift before the new block starts
         xfer_both_first: next_state = dataoutstart ? xfer_both_first : xfer_both_run;
         xfer_both_run: begin
            if (lastdataout) begin
               if (in_count == symbol_count_t'(`RS_SYMBOLS - 3)) begin
                  next_state = xfer_both_done_last;
               end else begin
                  next_state = xfer_both_done;
               end
            end
         end
         xfer_both_done_last: next_state = xfer_receive_last;
         xfer_both_done: next_state = xfer_receive;
         default: next_state = xfer_idle;
      endcase
   end

   always_comb begin
      datainfinish = 1'b0;
      dataoutend   = 1'b0;
      shift_fifo   = 1'b0;
      hold_fifo    = 1'b0;
      en_infifo    = 1'b0;
      holdsynd     = 1'b0;
      in_en        = 1'b0;
      out_en       = 1'b0;
      case (state)
         xfer_receive: begin
            shift_fifo = 1'b1;
            en_infifo  = 1'b1;
            in_en      = 1'b1;
         end
         xfer_receive_last: begin
            shift_fifo   = 1'b1;
            en_infifo    = 1'b1;
            datainfinish = 1'b1;
         end
         xfer_hold: begin
            hold_fifo = 1'b1;
            holdsynd  = 1'b1;
         end
         xfer_out_prime: begin
            hold_fifo = 1'b1;
            out_en    = 1'b1;
         end
         xfer_out_first, xfer_out_run, xfer_both_first: begin
            shift_fifo = 1'b1;
            out_en     = 1'b1;
         end
         xfer_out_done: dataoutend = 1'b1;
         xfer_both_run: begin
            shift_fifo = 1'b1;
            en_infifo  = 1'b1;
            in_en      = 1'b1;
            out_en     = 1'b1;
         end
         xfer_both_done_last, xfer_both_done: begin
            dataoutend = 1'b1;
            shift_fifo = 1'b1;
            en_infifo  = 1'b1;
            in_en      = 1'b1;
         end
         default: holdsynd = 1'b0;
      endcase
   end

endmodule

/* run.sh */
#!/bin/sh
# Compile the controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rs_decode_control_tb \
   -f tb.f -o rs_decode_control_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/rs_decode_control_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* tb.f */
+incdir+design
design/rs_ctrl_pkg.sv
design/decode_sequencer.sv
design/symbol_transfer.sv
design/rs_decode_control.sv
tests/rs_decode_control_assertions.sv
tests/rs_decode_control_tb.sv

/* tests/rs_decode_control_assertions.sv */
// Concurrent checks on the controller outputs, bound into rs_decode_control
// Evaluated on every rising clock1 edge while reset is released
`timescale 1ns/1ns

module rs_decode_control_assertions (
   input logic clock1,
   input logic reset,
   input logic shift_fifo,
   input logic hold_fifo,
   input logic dataoutstart,
   input logic evalerror,
   input logic lastdataout,
   input logic dataoutend,
   input logic errfound,
   input logic active_kes
);

   // FIFO either shifts or holds
   shift_hold_exclusive: assert property (
      @(posedge clock1) disable iff (!reset) !(shift_fifo && hold_fifo)
   ) else $error("shift_fifo and hold_fifo high in the same cycle");

   start_in_eval: assert property (
      @(posedge clock1) disable iff (!reset) dataoutstart |-> evalerror
   ) else $error("dataoutstart high without evalerror");

   // Output block ends one cycle after its last symbol
   last_then_end: assert property (
      @(posedge clock1) disable iff (!reset) lastdataout |=> dataoutend
   ) else $error("dataoutend missing after lastdataout");

   errfound_in_kes: assert property (
      @(posedge clock1) disable iff (!reset) errfound |-> active_kes
   ) else $error("errfound high without active_kes");

endmodule

bind rs_decode_control rs_decode_control_assertions assertions_i (
   .clock1       (clock1),
   .reset        (reset),
   .shift_fifo   (shift_fifo),
   .hold_fifo    (hold_fifo),
   .dataoutstart (dataoutstart),
   .evalerror    (evalerror),
   .lastdataout  (lastdataout),
   .dataoutend   (dataoutend),
   .errfound     (errfound),
   .active_kes   (active_kes)
);

/* tests/rs_decode_control_tb.sv */
// Directed testbench for the Reed-Solomon decoder main controller
// Stands in for the syndrome, KES and CSEE blocks through errdetect, finish_kes,
// rootcntr and lambda_degree, and counts the FIFO and phase strobes of each block
`timescale 1ns/1ns
`include "rs_ctrl_defs.svh"

module rs_decode_control_tb;
   import rs_ctrl_pkg::*;

   localparam int CLOCK_PERIOD    = 40;
   localparam int WATCHDOG_CYCLES = 2500;
   localparam int BLOCK_LIMIT     = 400;

   logic        clock1;
   logic        reset;
   logic        start;
   logic        errdetect;
   logic        finish_kes;
   degree_t     rootcntr;
   degree_t     lambda_degree;
   logic        ready;
   logic        active_sc;
   logic        active_kes;
   logic        active_csee;
   logic        evalsynd;
   logic        holdsynd;
   logic        errfound;
   logic        decode_fail;
   logic        dataoutstart;
   logic        dataoutend;
   logic        shift_fifo;
   logic        hold_fifo;
   logic        en_infifo;
   logic        en_outfifo;
   logic        lastdataout;
   logic        evalerror;
   logic        outfifo_q;
   logic [31:0] rand_state;
   int errors, checks, cycle;
   int in_run, out_shifts, out_starts, eval_run, last_pos, last_count;
   int n_evalsynd, n_errfound, n_csee, n_kes, n_ends, n_fail, n_finish, n_eval_runs;
   int n_sc;
   int early_out, end_cycle, fail_cycle, kes_cnt, kes_delay;

   rs_decode_control dut_i (.*);

   always #(CLOCK_PERIOD / 2) clock1 = ~clock1;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task expect_value(input string name, input int expected, input int actual);
      checks++;
      if (expected != actual) begin
         $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Advance one cycle, then sample the outputs and play the KES block
   task next_cycle;
      logic in_kes_wait;
      @(posedge clock1);
      #2;
      cycle++;
      if (en_infifo) in_run++;
      if (evalsynd) begin
         expect_value("en_infifo cycles", `RS_SYMBOLS, in_run);
         expect_value("hold_fifo during evalsynd", 1, int'(hold_fifo));
         expect_value("holdsynd during evalsynd", 1, int'(holdsynd));
         in_run = 0;
         n_evalsynd++;
      end
      if (active_sc) n_sc++;
      if (shift_fifo && evalerror) out_shifts++;
      if (dataoutstart) out_starts++;
      if (dataoutend) begin
         expect_value("output shift_fifo cycles", `RS_SYMBOLS, out_shifts);
         expect_value("dataoutstart pulses", 1, out_starts);
         out_shifts = 0;
         out_starts = 0;
         n_ends++;
         end_cycle = cycle;
      end
      if (evalerror) eval_run++;
      if (lastdataout) begin
         last_pos = eval_run;
         last_count++;
      end
      if (!evalerror && eval_run != 0) begin
         expect_value("evalerror run length", `RS_SYMBOLS + 1, eval_run);
         expect_value("lastdataout position in evalerror", `RS_SYMBOLS + 1, last_pos);
         expect_value("lastdataout cycles", 1, last_count);
         eval_run = 0;
         last_pos = 0;
         last_count = 0;
         n_eval_runs++;
      end
      if (errfound) n_errfound++;
      if (active_csee) n_csee++;
      if (active_kes) n_kes++;
      if (decode_fail) begin
         n_fail++;
         fail_cycle = cycle;
      end
      if (en_outfifo && !outfifo_q && errdetect && n_finish == 0) early_out++;
      outfifo_q = en_outfifo;
      in_kes_wait = active_kes && !ready && !errfound && !active_csee;
      if (in_kes_wait) kes_cnt++;
      finish_kes = in_kes_wait && (kes_cnt == kes_delay);
      if (finish_kes) n_finish++;
   endtask

   task clear_counts;
      n_evalsynd = 0;
      n_errfound = 0;
      n_csee = 0;
      n_kes = 0;
      n_ends = 0;
      n_fail = 0;
      n_finish = 0;
      n_eval_runs = 0;
      n_sc = 0;
      early_out = 0;
      kes_cnt = 0;
   endtask

   // Status for the new block, then a one-cycle start
   task begin_block(input logic err, input logic match);
      rand_state = xorshift(rand_state);
      errdetect = err;
      lambda_degree = rand_state[2:0];
      kes_delay = int'(rand_state[7:4]) + 1;
      rootcntr = match ? lambda_degree
                       : lambda_degree ^ degree_t'(rand_state % 32'd7 + 32'd1);
      start = 1'b1;
      next_cycle();
      start = 1'b0;
   endtask

   task wait_for_ends(input int count);
      int waited;
      waited = 0;
      while (n_ends < count && waited < BLOCK_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (n_ends < count) begin
         $display("ERROR at %0t: dataoutend did not arrive within %0d cycles", $time, BLOCK_LIMIT);
         errors++;
      end
      // A mismatch shows as decode_fail right after dataoutend
      next_cycle();
      next_cycle();
   endtask

   task check_reset_outputs;
      logic [14:0] others;
      others = {active_sc, active_kes, active_csee, evalsynd, holdsynd, errfound, decode_fail,
                dataoutstart, dataoutend, shift_fifo, hold_fifo, en_infifo, en_outfifo,
                lastdataout, evalerror};
      expect_value("ready after reset", 1, int'(ready));
      expect_value("outputs other than ready after reset", 0, int'(others));
   endtask

   task decode_clean_block;
      clear_counts();
      begin_block(1'b0, 1'b1);
      wait_for_ends(1);
      expect_value("active_sc cycles", 1, n_sc);
      expect_value("evalsynd pulses", 1, n_evalsynd);
      expect_value("active_kes cycles", 0, n_kes);
      expect_value("active_csee cycles", 0, n_csee);
      expect_value("dataoutend pulses", 1, n_ends);
      expect_value("decode_fail cycles", 0, n_fail);
      expect_value("ready", 1, int'(ready));
   endtask

   task decode_corrected_block;
      clear_counts();
      begin_block(1'b1, 1'b1);
      wait_for_ends(1);
      expect_value("errfound pulses", 1, n_errfound);
      expect_value("active_csee pulses", 1, n_csee);
      expect_value("finish_kes pulses", 1, n_finish);
      expect_value("en_outfifo rises before finish_kes", 0, early_out);
      expect_value("decode_fail cycles", 0, n_fail);
   endtask

   task decode_failed_block;
      clear_counts();
      begin_block(1'b1, 1'b0);
      wait_for_ends(1);
      expect_value("decode_fail cycles", 1, n_fail);
      expect_value("decode_fail delay after dataoutend", 1, fail_cycle - end_cycle);
      expect_value("ready", 1, int'(ready));
   endtask

   // Second start arrives while the corrected block is being output
   task overlap_blocks;
      int waited;
      clear_counts();
      begin_block(1'b1, 1'b1);
      waited = 0;
      while (!en_outfifo && waited < BLOCK_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (!en_outfifo) begin
         $display("ERROR at %0t: en_outfifo never rose for the corrected block", $time);
         errors++;
      end
      start = 1'b1;
      errdetect = 1'b0;
      next_cycle();
      start = 1'b0;
      wait_for_ends(2);
      expect_value("active_sc cycles", 2, n_sc);
      expect_value("evalsynd pulses", 2, n_evalsynd);
      expect_value("errfound pulses", 1, n_errfound);
      expect_value("dataoutend pulses", 2, n_ends);
      expect_value("decode_fail cycles", 0, n_fail);
      expect_value("ready", 1, int'(ready));
   endtask

   task measure_output_timing;
      clear_counts();
      begin_block(1'b0, 1'b1);
      wait_for_ends(1);
      expect_value("evalerror runs", 1, n_eval_runs);
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLOCK_PERIOD);
      $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

   initial begin
      clock1 = 1'b0;
      reset = 1'b0;
      start = 1'b0;
      errdetect = 1'b0;
      finish_kes = 1'b0;
      rootcntr = '0;
      lambda_degree = '0;
      outfifo_q = 1'b0;
      rand_state = 32'hbd25_0831;
      repeat (16) @(posedge clock1);
      #2 reset = 1'b1;
      check_reset_outputs();
      decode_clean_block();
      decode_corrected_block();
      decode_failed_block();
      overlap_blocks();
      measure_output_timing();
      $display("Finished with %0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
